//--- dv/mips_exe_asserts.sv
`default_nettype none
`timescale 1ns/100ps

module mips_exe_asserts (
    input logic clk,
    input logic arst_n,
    input logic push,
    input logic pop,
    input logic not_empty,
    input logic full,
    input logic result_valid
);

    logic [7:0] occupancy;    // pushes minus pops seen at the ports

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + 8'(push) - 8'(pop);
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) full |-> !push)
        else $error("push while the issue FIFO is full");

    assert property (@(posedge clk) disable iff (!arst_n) pop |-> (occupancy != 8'd0))
        else $error("pop from an empty issue FIFO");

    assert property (@(posedge clk) disable iff (!arst_n) not_empty == (occupancy != 8'd0))
        else $error("issue FIFO not_empty does not match its pushes and pops");

    assert property (@(posedge clk) disable iff (!arst_n) pop |=> result_valid)
        else $error("no result one cycle after a pop");

    // also rules out a result that lasts longer than one cycle
    assert property (@(posedge clk) disable iff (!arst_n) result_valid |-> $past(pop))
        else $error("result without a pop one cycle earlier");

    assert property (@(posedge clk) $rose(arst_n) |-> !result_valid)
        else $error("result valid right after reset");

endmodule

// FIFO strobes and result timing, seen from the top level
bind mips_exe_top mips_exe_asserts u_mips_exe_asserts (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (instr_valid),
    .pop          (pop),
    .not_empty    (not_empty),
    .full         (full),
    .result_valid (result_valid)
);

`default_nettype wire

//--- dv/mips_exe_tb.sv
`default_nettype none
`timescale 1ns/100ps

module mips_exe_tb;
    import isa_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam logic [5:0] REG_FN [8]   = '{ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU};
    localparam logic [5:0] IMM_OPC [6]  = '{ADDIU, SLTI, SLTIU, ANDI, ORI, XORI};
    localparam logic [5:0] SHIFT_FN [6] = '{SLL, SRL, SRA, SLLV, SRLV, SRAV};

    logic                 clk;
    logic                 arst_n;
    logic                 instr_valid;
    instr_u               instr;
    logic [31:0]          rs_val;
    logic [31:0]          rt_val;
    logic                 hold;
    logic                 full;
    logic                 result_valid;
    exe_pkg::exe_result_t result;

    exe_pkg::exe_result_t exp_q[$];   // predicted results in issue order
    int                   errors;
    int                   checks;
    int                   tests;

    mips_exe_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_mips_exe_top (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lead_count(input logic [31:0] v, input logic ones);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == ones) begin
            n++;
        end
        return 32'(n);
    endfunction

    // reference model straight from the ISA rules
    function automatic exe_pkg::exe_result_t predict(input instr_u w, input logic [31:0] rs,
                                                     input logic [31:0] rt);
        exe_pkg::exe_result_t r;
        logic [31:0] sx;
        logic [32:0] wide;
        logic        ok;
        logic        trap_op;
        sx      = {{16{w.i.imm16[15]}}, w.i.imm16};
        wide    = '0;
        ok      = 1'b1;
        trap_op = 1'b0;
        r       = '0;
        r.dest  = w.i.rt;
        if (w.r.opcode == SPECIAL || w.r.opcode == SPECIAL2) begin
            r.dest = w.r.rd;
        end
        if (w.r.opcode == SPECIAL) begin
            case (w.r.funct)
                ADD: begin
                    wide    = {rs[31], rs} + {rt[31], rt};
                    trap_op = 1'b1;
                end
                SUB: begin
                    wide    = {rs[31], rs} - {rt[31], rt};
                    trap_op = 1'b1;
                end
                ADDU:    r.value = rs + rt;
                SUBU:    r.value = rs - rt;
                AND:     r.value = rs & rt;
                OR:      r.value = rs | rt;
                XOR:     r.value = rs ^ rt;
                NOR:     r.value = ~(rs | rt);
                SLT:     r.value = 32'($signed(rs) < $signed(rt));
                SLTU:    r.value = 32'(rs < rt);
                SLL:     r.value = rt << w.r.shamt;
                SRL:     r.value = rt >> w.r.shamt;
                SRA:     r.value = $signed(rt) >>> w.r.shamt;
                SLLV:    r.value = rt << rs[4:0];
                SRLV:    r.value = rt >> rs[4:0];
                SRAV:    r.value = $signed(rt) >>> rs[4:0];
                default: ok = 1'b0;
            endcase
        end else if (w.r.opcode == SPECIAL2) begin
            case (w.r.funct)
                CLZ:     r.value = lead_count(rs, 1'b0);
                CLO:     r.value = lead_count(rs, 1'b1);
                default: ok = 1'b0;
            endcase
        end else begin
            case (w.i.opcode)
                ADDI: begin
                    wide    = {rs[31], rs} + {sx[31], sx};
                    trap_op = 1'b1;
                end
                ADDIU:   r.value = rs + sx;
                SLTI:    r.value = 32'($signed(rs) < $signed(sx));
                SLTIU:   r.value = 32'(rs < sx);
                ANDI:    r.value = rs & {16'h0, w.i.imm16};
                ORI:     r.value = rs | {16'h0, w.i.imm16};
                XORI:    r.value = rs ^ {16'h0, w.i.imm16};
                default: ok = 1'b0;
            endcase
        end
        if (trap_op) begin
            r.value    = wide[31:0];
            r.overflow = wide[32] ^ wide[31];   // sign bits disagree
        end
        r.illegal = !ok;
        r.wr_en   = ok && (r.dest != 5'd0) && !r.overflow;
        return r;
    endfunction

    function automatic instr_u r_word(input logic [5:0] opc, input logic [5:0] fn);
        instr_u w;
        w.r.opcode = opc;
        w.r.rs     = 5'($urandom_range(0, 31));
        w.r.rt     = 5'($urandom_range(0, 31));
        w.r.rd     = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
        w.r.shamt  = 5'($urandom_range(0, 31));
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic instr_u i_word(input logic [5:0] opc);
        instr_u w;
        w.i.opcode = opc;
        w.i.rs     = 5'($urandom_range(0, 31));
        w.i.rt     = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
        w.i.imm16  = 16'($urandom());
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // called on a falling edge and returns on the next one
    task automatic send(input instr_u w, input logic [31:0] rs, input logic [31:0] rt);
        instr       = w;
        rs_val      = rs;
        rt_val      = rt;
        instr_valid = 1'b1;
        exp_q.push_back(predict(w, rs, rt));
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic send_trap_case(input logic [5:0] fn, input logic [31:0] rs,
                                  input logic [31:0] rt);
        instr_u w;
        w      = r_word(SPECIAL, fn);
        w.r.rd = 5'd5;                        // nonzero so wr_en clearing is visible
        send(w, rs, rt);
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: result did not arrive, %0d missing", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        @(negedge clk);                       // room for a stray extra result
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %s %s (%0d errors)", name,
                 (errors == err_before) ? "done" : "FAILED", errors - err_before);
    endtask

    always @(negedge clk) begin : check_results
        exe_pkg::exe_result_t want;
        if (arst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("error at t=%0t: result arrived with none expected", $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                check_value("result.value", result.value, want.value);
                check_value("result.dest", 32'(result.dest), 32'(want.dest));
                check_value("result.wr_en", 32'(result.wr_en), 32'(want.wr_en));
                check_value("result.overflow", 32'(result.overflow), 32'(want.overflow));
                check_value("result.illegal", 32'(result.illegal), 32'(want.illegal));
            end
        end
    end

    initial begin
        instr_u w;
        int     err_before;
        void'($urandom(9356));
        errors      = 0;
        checks      = 0;
        tests       = 0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rs_val      = '0;
        rt_val      = '0;
        hold        = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        err_before = errors;
        check_value("full", 32'(full), 32'd0);
        check_value("result_valid", 32'(result_valid), 32'd0);
        send(r_word(SPECIAL, ADDU), $urandom(), $urandom());
        check_value("result_valid", 32'(result_valid), 32'd0);   // popped on the next edge
        @(negedge clk);
        check_value("result_valid", 32'(result_valid), 32'd1);
        drain("reset");
        report_test("reset", err_before);

        err_before = errors;
        repeat (40) send(r_word(SPECIAL, REG_FN[$urandom_range(0, 7)]), $urandom(), $urandom());
        drain("register");
        report_test("register", err_before);

        err_before = errors;
        repeat (40) send(i_word(IMM_OPC[$urandom_range(0, 5)]), $urandom(), $urandom());
        drain("immediate");
        report_test("immediate", err_before);

        err_before = errors;
        repeat (30) send(r_word(SPECIAL, SHIFT_FN[$urandom_range(0, 5)]), $urandom(), $urandom());
        repeat (10) send(r_word(SPECIAL2, CLZ), $urandom() >> $urandom_range(0, 31), $urandom());
        repeat (10) send(r_word(SPECIAL2, CLO), ~($urandom() >> $urandom_range(0, 31)), 0);
        send(r_word(SPECIAL2, CLZ), 32'h0, $urandom());
        send(r_word(SPECIAL2, CLO), 32'hffff_ffff, $urandom());
        send(r_word(SPECIAL2, CLZ), 32'hffff_ffff, $urandom());
        send(r_word(SPECIAL2, CLO), 32'h0, $urandom());
        drain("shift/count");
        report_test("shift/count", err_before);

        err_before = errors;
        send_trap_case(ADD, 32'h7fff_ffff, 32'h1);
        send_trap_case(ADDU, 32'h7fff_ffff, 32'h1);
        send_trap_case(ADD, 32'h8000_0000, 32'hffff_ffff);
        send_trap_case(SUB, 32'h8000_0000, 32'h1);
        send_trap_case(SUBU, 32'h8000_0000, 32'h1);
        w         = i_word(ADDI);
        w.i.rt    = 5'd7;
        w.i.imm16 = 16'h7fff;
        send(w, 32'h7fff_ffff, $urandom());
        w.i.opcode = ADDIU;
        send(w, 32'h7fff_ffff, $urandom());
        send_trap_case(6'h01, $urandom(), $urandom());   // unknown funct
        send(r_word(SPECIAL2, 6'h3f), $urandom(), $urandom());
        send(i_word(6'h3f), $urandom(), $urandom());
        drain("overflow");
        report_test("overflow", err_before);

        err_before = errors;
        hold = 1'b1;
        repeat (FIFO_DEPTH) send(r_word(SPECIAL, REG_FN[$urandom_range(0, 7)]), $urandom(), 1);
        check_value("full", 32'(full), 32'd1);
        check_value("result_valid", 32'(result_valid), 32'd0);
        hold = 1'b0;
        drain("back-pressure");
        repeat (80) begin
            hold = 1'($urandom_range(0, 1));
            if (!full && $urandom_range(0, 2) != 0) begin
                send(r_word(SPECIAL, REG_FN[$urandom_range(0, 7)]), $urandom(), $urandom());
            end else begin
                @(negedge clk);
            end
        end
        hold = 1'b0;
        drain("back-pressure");
        report_test("back-pressure", err_before);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/alu.sv
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  exe_pkg::alu_op_e  op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       value,
    output logic              overflow
);
    import exe_pkg::*;

    logic        cnt_ones;
    logic [31:0] cnt_out;

    // select is defined for every op, clz unless clo
    assign cnt_ones = (op == CLO);

    count_leading u_count_leading (
        .count_ones (cnt_ones),
        .value      (a),
        .count      (cnt_out)
    );

    always_comb begin
        unique case (op)
            ADD, ADDU: value = a + b;
            SUB, SUBU: value = a - b;
            AND:       value = a & b;
            OR:        value = a | b;
            XOR:       value = a ^ b;
            NOR:       value = ~(a | b);
            SLL:       value = b << a[4:0];
            SRL:       value = b >> a[4:0];
            SRA:       value = $signed(b) >>> a[4:0];
            SLT:       value = {31'b0, $signed(a) < $signed(b)};
            SLTU:      value = {31'b0, a < b};
            CLZ, CLO:  value = cnt_out;
            default:   value = '0;     // NONE, nothing to compute
        endcase
    end

    // signed overflow, unsigned forms never trap
    assign overflow = ((op == ADD) && (a[31] == b[31]) && (value[31] != a[31])) ||
                      ((op == SUB) && (a[31] != b[31]) && (value[31] != a[31]));

endmodule

`default_nettype wire

//--- hw/count_leading.sv
`default_nettype none
`timescale 1ns/100ps

module count_leading (
    input  logic        count_ones,
    input  logic [31:0] value,
    output logic [31:0] count
);
    logic [31:0] bits;

    // turn leading ones into leading zeros
    assign bits = count_ones ? ~value : value;

    always_comb begin
        logic run;

        run   = 1'b1;
        count = '0;
        for (int k = 31; k >= 0; k--) begin
            if (run && !bits[k]) begin
                count = count + 32'd1;
            end else begin
                run = 1'b0;     // first differing bit ends the run
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/exe_pkg.sv
`default_nettype none

package exe_pkg;

    // register and immediate forms map to one op
    typedef enum logic [4:0] {
        NONE = 5'd0,
        ADD,
        ADDU,
        SUB,
        SUBU,
        OR,
        AND,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        CLZ,
        CLO
    } alu_op_e;

    typedef struct packed {
        alu_op_e     op;
        logic [31:0] a;        // shift amount for shifts
        logic [31:0] b;        // value to shift for shifts
        logic [4:0]  dest;
        logic        wr_en;
        logic        illegal;
    } exe_issue_t;

    typedef struct packed {
        logic [31:0] value;
        logic [4:0]  dest;
        logic        wr_en;     // already cleared on overflow
        logic        overflow;
        logic        illegal;
    } exe_result_t;

endpackage

`default_nettype wire

//--- hw/exe_stage.sv
`default_nettype none
`timescale 1ns/100ps

module exe_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  exe_pkg::exe_issue_t   head,
    input  logic                  not_empty,
    input  logic                  hold,
    output logic                  pop,
    output logic                  result_valid,
    output exe_pkg::exe_result_t  result
);
    logic [31:0] alu_value;
    logic        alu_ovf;

    assign pop = not_empty && !hold;    // consume head this edge

    alu u_alu (
        .op       (head.op),
        .a        (head.a),
        .b        (head.b),
        .value    (alu_value),
        .overflow (alu_ovf)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= pop;
        end
    end

    // last result stays put while nothing pops
    always_ff @(posedge clk) begin
        if (pop) begin
            result.value    <= alu_value;
            result.dest     <= head.dest;
            result.wr_en    <= head.wr_en && !alu_ovf;  // trapping add writes nothing
            result.overflow <= alu_ovf;
            result.illegal  <= head.illegal;
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module instr_decoder (
    input  isa_pkg::instr_u       instr,
    input  logic [31:0]           rs_val,
    input  logic [31:0]           rt_val,
    output exe_pkg::exe_issue_t   issue
);
    import isa_pkg::*;
    import exe_pkg::*;

    // funct codes and alu ops share names, so those stay qualified
    always_comb begin
        logic known;

        known         = 1'b1;
        issue.op      = NONE;
        issue.a       = rs_val;
        issue.b       = rt_val;
        issue.dest    = instr.r.rd;    // R-format default
        issue.illegal = 1'b0;

        case (instr.r.opcode)
            SPECIAL: begin
                case (instr.r.funct)
                    isa_pkg::ADD:  issue.op = exe_pkg::ADD;
                    isa_pkg::ADDU: issue.op = exe_pkg::ADDU;
                    isa_pkg::SUB:  issue.op = exe_pkg::SUB;
                    isa_pkg::SUBU: issue.op = exe_pkg::SUBU;
                    isa_pkg::AND:  issue.op = exe_pkg::AND;
                    isa_pkg::OR:   issue.op = exe_pkg::OR;
                    isa_pkg::XOR:  issue.op = exe_pkg::XOR;
                    isa_pkg::NOR:  issue.op = exe_pkg::NOR;
                    isa_pkg::SLT:  issue.op = exe_pkg::SLT;
                    isa_pkg::SLTU: issue.op = exe_pkg::SLTU;
                    isa_pkg::SLL: begin
                        issue.op = exe_pkg::SLL;
                        issue.a  = {27'b0, instr.r.shamt};
                    end
                    isa_pkg::SRL: begin
                        issue.op = exe_pkg::SRL;
                        issue.a  = {27'b0, instr.r.shamt};
                    end
                    isa_pkg::SRA: begin
                        issue.op = exe_pkg::SRA;
                        issue.a  = {27'b0, instr.r.shamt};
                    end
                    SLLV:    issue.op = exe_pkg::SLL;    // amount from rs
                    SRLV:    issue.op = exe_pkg::SRL;
                    SRAV:    issue.op = exe_pkg::SRA;
                    default: known = 1'b0;
                endcase
            end
            SPECIAL2: begin
                case (instr.r.funct)
                    isa_pkg::CLZ: issue.op = exe_pkg::CLZ;
                    isa_pkg::CLO: issue.op = exe_pkg::CLO;
                    default:      known = 1'b0;
                endcase
            end
            default: begin
                issue.dest = instr.i.rt;
                issue.b    = {{16{instr.i.imm16[15]}}, instr.i.imm16};  // sign extend
                case (instr.i.opcode)
                    ADDI:    issue.op = exe_pkg::ADD;
                    ADDIU:   issue.op = exe_pkg::ADDU;
                    SLTI:    issue.op = exe_pkg::SLT;
                    SLTIU:   issue.op = exe_pkg::SLTU;
                    ANDI: begin
                        issue.op = exe_pkg::AND;
                        issue.b  = {16'b0, instr.i.imm16};    // logic ops zero extend
                    end
                    ORI: begin
                        issue.op = exe_pkg::OR;
                        issue.b  = {16'b0, instr.i.imm16};
                    end
                    XORI: begin
                        issue.op = exe_pkg::XOR;
                        issue.b  = {16'b0, instr.i.imm16};
                    end
                    default: known = 1'b0;
                endcase
            end
        endcase

        issue.illegal = !known;
        issue.wr_en   = known && (issue.dest != 5'd0);  // $zero never written
    end

endmodule

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // register format, also used for SPECIAL2
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // same 32 bits, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    localparam logic [5:0] SPECIAL  = 6'h00;
    localparam logic [5:0] SPECIAL2 = 6'h1c;
    localparam logic [5:0] ADDI     = 6'h08;
    localparam logic [5:0] ADDIU    = 6'h09;
    localparam logic [5:0] SLTI     = 6'h0a;
    localparam logic [5:0] SLTIU    = 6'h0b;
    localparam logic [5:0] ANDI     = 6'h0c;
    localparam logic [5:0] ORI      = 6'h0d;
    localparam logic [5:0] XORI     = 6'h0e;

    localparam logic [5:0] SLL      = 6'h00;
    localparam logic [5:0] SRL      = 6'h02;
    localparam logic [5:0] SRA      = 6'h03;
    localparam logic [5:0] SLLV     = 6'h04;
    localparam logic [5:0] SRLV     = 6'h06;
    localparam logic [5:0] SRAV     = 6'h07;
    localparam logic [5:0] ADD      = 6'h20;
    localparam logic [5:0] ADDU     = 6'h21;
    localparam logic [5:0] SUB      = 6'h22;
    localparam logic [5:0] SUBU     = 6'h23;
    localparam logic [5:0] AND      = 6'h24;
    localparam logic [5:0] OR       = 6'h25;
    localparam logic [5:0] XOR      = 6'h26;
    localparam logic [5:0] NOR      = 6'h27;
    localparam logic [5:0] SLT      = 6'h2a;
    localparam logic [5:0] SLTU     = 6'h2b;

    localparam logic [5:0] CLZ      = 6'h20;  // funct under SPECIAL2
    localparam logic [5:0] CLO      = 6'h21;  // funct under SPECIAL2

endpackage

`default_nettype wire

//--- hw/issue_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module issue_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  push,
    input  exe_pkg::exe_issue_t   issue_in,
    input  logic                  pop,
    output exe_pkg::exe_issue_t   head,
    output logic                  not_empty,
    output logic                  full
);
    import exe_pkg::*;

    localparam int             PTR_W    = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

    exe_issue_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_pop    = pop && not_empty;
    assign do_push   = push && (!full || do_pop);   // full is fine if a slot frees now
    assign not_empty = (count != '0);
    assign full      = (count == FULL_CNT);
    assign head      = mem[rd_ptr];                 // show-ahead

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= issue_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/mips_exe_top.sv
`default_nettype none
`timescale 1ns/100ps

module mips_exe_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  isa_pkg::instr_u       instr,
    input  logic [31:0]           rs_val,
    input  logic [31:0]           rt_val,
    input  logic                  hold,
    output logic                  full,
    output logic                  result_valid,
    output exe_pkg::exe_result_t  result
);
    import exe_pkg::*;

    exe_issue_t issue;
    exe_issue_t head;
    logic       not_empty;
    logic       pop;

    instr_decoder u_instr_decoder (
        .instr  (instr),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .issue  (issue)
    );

    issue_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_issue_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (instr_valid),
        .issue_in  (issue),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .full      (full)
    );

    exe_stage u_exe_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .head         (head),
        .not_empty    (not_empty),
        .hold         (hold),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- mips_exe.f
hw/isa_pkg.sv
hw/exe_pkg.sv
hw/count_leading.sv
hw/alu.sv
hw/instr_decoder.sv
hw/issue_fifo.sv
hw/exe_stage.sv
hw/mips_exe_top.sv
dv/mips_exe_asserts.sv
dv/mips_exe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mips_exe testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mips_exe_tb -Mdir obj_dir -f mips_exe.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmips_exe_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$log"; then
    echo "result: FAIL"
    exit 1
fi
echo "result: PASS"
exit 0
